/* Bender.yml */
package:
  name: exe_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/exe_pkg.sv
      - rtl/operand_forward.sv
      - rtl/alu.sv
      - rtl/div_unit.sv
      - rtl/branch_resolve.sv
      - rtl/exe_writeback_reg.sv
      - rtl/exe_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_exe_stage.sv

/* filelist.f */
+incdir+include
rtl/exe_pkg.sv
rtl/operand_forward.sv
rtl/alu.sv
rtl/div_unit.sv
rtl/branch_resolve.sv
rtl/exe_writeback_reg.sv
rtl/exe_stage.sv
sim/tb_exe_stage.sv

/* include/exe_defines.svh */
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// datapath width
`define EXE_XLEN 32

// register file address width
`define EXE_REG_AW 5

// start to done latency of the divider
// one load cycle plus one step per quotient bit
`define EXE_DIV_CYCLES 33

`endif

/* rtl/alu.sv */
`timescale 1ns/1ns
`include "exe_defines.svh"

module alu (
    input  exe_pkg::alu_op_t     alu_op,
    input  logic [`EXE_XLEN-1:0] src1,
    input  logic [`EXE_XLEN-1:0] src2,
    output logic [`EXE_XLEN-1:0] result,
    output logic                 zero,
    output logic                 less
);

    localparam int SHW = $clog2(`EXE_XLEN);

    logic [`EXE_XLEN-1:0] sum;
    logic [`EXE_XLEN-1:0] diff;
    logic [SHW-1:0]       shamt;
    logic                 slt_res;
    logic                 sltu_res;
    logic [`EXE_XLEN-1:0] sra_res;

    assign sum      = src1 + src2;
    assign diff     = src1 - src2;
    assign shamt    = src2[SHW-1:0];  // low five bits only
    assign slt_res  = $signed(src1) < $signed(src2);
    assign sltu_res = src1 < src2;
    assign sra_res  = $unsigned($signed(src1) >>> shamt);

    // flags feed branch resolution
    assign zero = (src1 == src2);
    assign less = alu_op.slt ? slt_res : sltu_res;

    // and-or mux, one lane is live at a time
    always_comb
    begin
        result = {`EXE_XLEN{alu_op.add}}    & sum
               | {`EXE_XLEN{alu_op.sub}}    & diff
               | {`EXE_XLEN{alu_op.slt}}    & {{(`EXE_XLEN-1){1'b0}}, slt_res}
               | {`EXE_XLEN{alu_op.sltu}}   & {{(`EXE_XLEN-1){1'b0}}, sltu_res}
               | {`EXE_XLEN{alu_op.op_and}} & (src1 & src2)
               | {`EXE_XLEN{alu_op.op_nor}} & ~(src1 | src2)
               | {`EXE_XLEN{alu_op.op_or}}  & (src1 | src2)
               | {`EXE_XLEN{alu_op.op_xor}} & (src1 ^ src2)
               | {`EXE_XLEN{alu_op.sll}}    & (src1 << shamt)
               | {`EXE_XLEN{alu_op.srl}}    & (src1 >> shamt)
               | {`EXE_XLEN{alu_op.sra}}    & sra_res
               | {`EXE_XLEN{alu_op.lui}}    & src2;  // immediate already shifted by decode
    end

    // decode must never select two operations at once
    always_comb
    begin
        assert final ($isunknown(alu_op) || $onehot0(alu_op))
            else $error("alu_op not one-hot: %b", alu_op);
    end

endmodule

/* rtl/branch_resolve.sv */
`timescale 1ns/1ns
`include "exe_defines.svh"

module branch_resolve (
    input  logic                   valid,
    input  exe_pkg::branch_ctl_t   ctl,
    input  logic [`EXE_XLEN-1:0]   pc,
    input  logic [`EXE_XLEN-1:0]   imm,
    input  logic [`EXE_XLEN-1:0]   rj_value,
    input  logic                   zero,
    input  logic                   less,
    output exe_pkg::br_t           br_bus,
    output exe_pkg::bpu_upd_t      bpu_upd
);

    logic                 cond_ok;
    logic                 taken;
    logic                 mispredict;
    logic [`EXE_XLEN-1:0] br_target;
    logic [`EXE_XLEN-1:0] seq_pc;

    // unconditional when neither flag is consulted
    assign cond_ok = (!ctl.use_less && !ctl.use_zero)
                   || (ctl.use_less && (less == ctl.need_less))
                   || (ctl.use_zero && (zero == ctl.need_zero));

    assign taken      = ctl.may_jump && cond_ok;
    assign mispredict = taken != ctl.pred_taken;

    assign br_target = (ctl.use_rj_value ? rj_value : pc) + imm;
    assign seq_pc    = pc + `EXE_XLEN'd4;

    // redirect to the real next pc
    assign br_bus.flush  = mispredict && valid;
    assign br_bus.target = taken ? br_target : seq_pc;

    assign bpu_upd.valid      = valid && ctl.may_jump;
    assign bpu_upd.pc         = pc;
    assign bpu_upd.taken      = taken;
    assign bpu_upd.mispredict = mispredict;
    assign bpu_upd.target     = br_target;
    assign bpu_upd.spare      = 1'b0;

endmodule

/* rtl/div_unit.sv */
`timescale 1ns/1ns
`include "exe_defines.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 div_signed,
    input  logic                 use_mod,
    input  logic [`EXE_XLEN-1:0] x,
    input  logic [`EXE_XLEN-1:0] y,
    output logic [`EXE_XLEN-1:0] result,
    output logic                 busy,
    output logic                 done
);

    localparam int CNT_W = $clog2(`EXE_DIV_CYCLES);
    localparam int MSB   = `EXE_XLEN - 1;

    logic [CNT_W-1:0]     step;
    logic [`EXE_XLEN-1:0] x_abs;
    logic [`EXE_XLEN-1:0] y_abs;
    logic [`EXE_XLEN-1:0] quo;   // dividend shifts out, quotient shifts in
    logic [`EXE_XLEN-1:0] rem;
    logic [`EXE_XLEN-1:0] dvs;
    logic [`EXE_XLEN:0]   trial;
    logic                 q_neg;
    logic                 r_neg;
    logic                 mod_sel;

    assign x_abs = (div_signed && x[MSB]) ? -x : x;
    assign y_abs = (div_signed && y[MSB]) ? -y : y;

    // partial remainder with next dividend bit, minus divisor
    assign trial = {rem, quo[MSB]} - {1'b0, dvs};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end
        else
        begin
            done <= 1'b0;  // single cycle pulse
            if (start)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (step == CNT_W'(`EXE_DIV_CYCLES - 2))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            quo     <= x_abs;
            rem     <= '0;
            dvs     <= y_abs;
            q_neg   <= div_signed & (x[MSB] ^ y[MSB]);
            r_neg   <= div_signed & x[MSB];  // remainder follows the dividend
            mod_sel <= use_mod;
        end
        else if (busy)
        begin
            if (!trial[`EXE_XLEN])
            begin
                rem <= trial[MSB:0];
                quo <= {quo[MSB-1:0], 1'b1};
            end
            else
            begin
                rem <= {rem[MSB-1:0], quo[MSB]};  // restore
                quo <= {quo[MSB-1:0], 1'b0};
            end
        end
    end

    // registers are frozen after the last step so this holds until the next start
    assign result = mod_sel ? (r_neg ? -rem : rem)
                            : (q_neg ? -quo : quo);

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("divider started while busy");

endmodule

/* rtl/exe_pkg.sv */
`include "exe_defines.svh"

package exe_pkg;

    // one-hot, add sits in bit 0 and lui in bit 11
    typedef struct packed {
        logic lui;
        logic sra;
        logic srl;
        logic sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic sltu;
        logic slt;
        logic sub;
        logic add;
    } alu_op_t;

    typedef struct packed {
        logic may_jump;
        logic use_rj_value;  // jirl style target
        logic use_less;
        logic need_less;
        logic use_zero;
        logic need_zero;
        logic pred_taken;    // front-end guess
        logic src1_is_pc;
        logic src2_is_imm;
    } branch_ctl_t;

    typedef struct packed {
        alu_op_t                  alu_op;
        branch_ctl_t              branch_ctl;
        logic                     src2_is_4;
        logic                     gr_we;
        logic [`EXE_REG_AW-1:0]   dest;
        logic [`EXE_XLEN-1:0]     imm;
        logic [`EXE_REG_AW-1:0]   rf_raddr1;
        logic [`EXE_REG_AW-1:0]   rf_raddr2;
        logic [`EXE_XLEN-1:0]     rj_value;   // register file copy
        logic [`EXE_XLEN-1:0]     rkd_value;  // register file copy
        logic [`EXE_XLEN-1:0]     pc;
        logic                     use_div;
        logic                     div_signed;
        logic                     use_mod;
    } issue_t;

    typedef struct packed {
        logic                     valid;
        logic                     we;
        logic [`EXE_REG_AW-1:0]   dest;
        logic [`EXE_XLEN-1:0]     data;
    } fwd_t;

    typedef struct packed {
        logic                     gr_we;
        logic [`EXE_REG_AW-1:0]   dest;
        logic [`EXE_XLEN-1:0]     result;
        logic [`EXE_XLEN-1:0]     pc;
    } wb_t;

    typedef struct packed {
        logic                     flush;
        logic [`EXE_XLEN-1:0]     target;
    } br_t;

    typedef struct packed {
        logic                     valid;
        logic [`EXE_XLEN-1:0]     pc;
        logic                     taken;
        logic                     mispredict;
        logic [`EXE_XLEN-1:0]     target;
        logic                     spare;
    } bpu_upd_t;

endpackage

/* rtl/exe_stage.sv */
`timescale 1ns/1ns
`include "exe_defines.svh"

module exe_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  exe_pkg::issue_t     in_bus,
    input  exe_pkg::fwd_t       fwd_1,
    input  exe_pkg::fwd_t       fwd_2,
    input  logic                ws_ready,
    output logic                ready,
    output logic                stall_n,
    output logic                out_valid,
    output exe_pkg::wb_t        out_bus,
    output exe_pkg::br_t        br_bus,
    output exe_pkg::bpu_upd_t   bpu_upd
);

    logic [`EXE_XLEN-1:0] rj_value;
    logic [`EXE_XLEN-1:0] rkd_value;
    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;
    logic [`EXE_XLEN-1:0] alu_result;
    logic [`EXE_XLEN-1:0] div_result;
    logic                 zero;
    logic                 less;
    logic                 div_start;
    logic                 div_busy;
    logic                 div_done;

    assign ready = ws_ready;  // no buffering of our own

    assign src1 = in_bus.branch_ctl.src1_is_pc ? in_bus.pc : rj_value;
    assign src2 = in_bus.branch_ctl.src2_is_imm ? in_bus.imm
                : in_bus.src2_is_4              ? `EXE_XLEN'd4
                :                                 rkd_value;

    operand_forward i_operand_forward (
        .raddr1    (in_bus.rf_raddr1),
        .raddr2    (in_bus.rf_raddr2),
        .rf_rj     (in_bus.rj_value),
        .rf_rkd    (in_bus.rkd_value),
        .fwd_1     (fwd_1),
        .fwd_2     (fwd_2),
        .rj_value  (rj_value),
        .rkd_value (rkd_value)
    );

    alu i_alu (
        .alu_op (in_bus.alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result),
        .zero   (zero),
        .less   (less)
    );

    div_unit i_div_unit (
        .clk        (clk),
        .reset      (reset),
        .start      (div_start),
        .div_signed (in_bus.div_signed),
        .use_mod    (in_bus.use_mod),
        .x          (src1),
        .y          (src2),
        .result     (div_result),
        .busy       (div_busy),
        .done       (div_done)
    );

    // target adds to the forwarded rj, not src1
    branch_resolve i_branch_resolve (
        .valid    (in_valid),
        .ctl      (in_bus.branch_ctl),
        .pc       (in_bus.pc),
        .imm      (in_bus.imm),
        .rj_value (rj_value),
        .zero     (zero),
        .less     (less),
        .br_bus   (br_bus),
        .bpu_upd  (bpu_upd)
    );

    exe_writeback_reg i_exe_writeback_reg (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .ws_ready   (ws_ready),
        .gr_we      (in_bus.gr_we),
        .use_div    (in_bus.use_div),
        .div_done   (div_done),
        .div_busy   (div_busy),
        .dest       (in_bus.dest),
        .pc         (in_bus.pc),
        .alu_result (alu_result),
        .div_result (div_result),
        .div_start  (div_start),
        .stall_n    (stall_n),
        .out_valid  (out_valid),
        .out_bus    (out_bus)
    );

endmodule

/* rtl/exe_writeback_reg.sv */
`timescale 1ns/1ns
`include "exe_defines.svh"

module exe_writeback_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic                   ws_ready,
    input  logic                   gr_we,
    input  logic                   use_div,
    input  logic                   div_done,
    input  logic                   div_busy,
    input  logic [`EXE_REG_AW-1:0] dest,
    input  logic [`EXE_XLEN-1:0]   pc,
    input  logic [`EXE_XLEN-1:0]   alu_result,
    input  logic [`EXE_XLEN-1:0]   div_result,
    output logic                   div_start,
    output logic                   stall_n,
    output logic                   out_valid,
    output exe_pkg::wb_t           out_bus
);

    logic div_ready;  // quotient waiting for writeback to take it
    logic accept;

    assign div_start = in_valid && use_div && !div_busy && !div_done && !div_ready;

    // low from start until the divider reports done
    assign stall_n = !(in_valid && use_div) || div_done || div_ready;

    assign accept = in_valid && stall_n && ws_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_ready <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (accept)
                div_ready <= 1'b0;
            else if (div_done)
                div_ready <= 1'b1;  // writeback stalled on the done cycle

            if (ws_ready)
                out_valid <= accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out_bus.gr_we  <= gr_we;
            out_bus.dest   <= dest;
            out_bus.result <= use_div ? div_result : alu_result;
            out_bus.pc     <= pc;
        end
    end

    a_out_valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid))
        else $error("out_valid unknown");

endmodule

/* rtl/operand_forward.sv */
`timescale 1ns/1ns
`include "exe_defines.svh"

module operand_forward (
    input  logic [`EXE_REG_AW-1:0] raddr1,
    input  logic [`EXE_REG_AW-1:0] raddr2,
    input  logic [`EXE_XLEN-1:0]   rf_rj,
    input  logic [`EXE_XLEN-1:0]   rf_rkd,
    input  exe_pkg::fwd_t          fwd_1,
    input  exe_pkg::fwd_t          fwd_2,
    output logic [`EXE_XLEN-1:0]   rj_value,
    output logic [`EXE_XLEN-1:0]   rkd_value
);

    logic rj_hit_1;
    logic rj_hit_2;
    logic rkd_hit_1;
    logic rkd_hit_2;

    // r0 never forwards, it always reads as zero from the file copy
    function automatic logic fwd_hit(
        input exe_pkg::fwd_t          bus,
        input logic [`EXE_REG_AW-1:0] addr
    );
        fwd_hit = bus.valid && bus.we && (|bus.dest) && (bus.dest == addr);
    endfunction

    assign rj_hit_1  = fwd_hit(fwd_1, raddr1);
    assign rj_hit_2  = fwd_hit(fwd_2, raddr1);
    assign rkd_hit_1 = fwd_hit(fwd_1, raddr2);
    assign rkd_hit_2 = fwd_hit(fwd_2, raddr2);

    // fwd_2 checked first so it wins on a double hit
    always_comb
    begin
        if (rj_hit_2)
            rj_value = fwd_2.data;
        else if (rj_hit_1)
            rj_value = fwd_1.data;
        else
            rj_value = rf_rj;
    end

    always_comb
    begin
        if (rkd_hit_2)
            rkd_value = fwd_2.data;
        else if (rkd_hit_1)
            rkd_value = fwd_1.data;
        else
            rkd_value = rf_rkd;  // no producer in flight
    end

endmodule

/* sim/tb_exe_stage.sv */
`timescale 1ns/1ns

module tb_exe_stage;

    localparam int TIMEOUT_CYCLES = 4000;

    logic                clk;
    logic                reset;
    logic                in_valid;
    exe_pkg::issue_t     in_bus;
    exe_pkg::fwd_t       fwd_1;
    exe_pkg::fwd_t       fwd_2;
    logic                ws_ready;
    logic                ready;
    logic                stall_n;
    logic                out_valid;
    exe_pkg::wb_t        out_bus;
    exe_pkg::br_t        br_bus;
    exe_pkg::bpu_upd_t   bpu_upd;

    logic [15:0] lfsr_state;
    int          cycle_count = 0;
    int          check_count;
    int          error_count;
    int          test_errors;  // error count when the current test began

    exe_stage i_exe_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_bus    (in_bus),
        .fwd_1     (fwd_1),
        .fwd_2     (fwd_2),
        .ws_ready  (ws_ready),
        .ready     (ready),
        .stall_n   (stall_n),
        .out_valid (out_valid),
        .out_bus   (out_bus),
        .br_bus    (br_bus),
        .bpu_upd   (bpu_upd)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, DUT stopped responding", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    // bit order add, sub, slt, sltu, and, nor, or, xor, sll, srl, sra, lui
    function automatic logic [31:0] alu_model(input int op, input logic [31:0] a, b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return {31'b0, $signed(a) < $signed(b)};
            3:       return {31'b0, a < b};
            4:       return a & b;
            5:       return ~(a | b);
            6:       return a | b;
            7:       return a ^ b;
            8:       return a << b[4:0];
            9:       return a >> b[4:0];
            10:      return $signed(a) >>> b[4:0];
            default: return b;
        endcase
    endfunction

    function automatic logic [31:0] div_model(input logic [31:0] a, b,
                                              input logic sgn, modsel);
        logic [31:0] am;
        logic [31:0] bm;
        logic [31:0] q;
        logic [31:0] r;
        am = (sgn && a[31]) ? -a : a;
        bm = (sgn && b[31]) ? -b : b;
        q  = am / bm;
        r  = am % bm;
        if (modsel)
            return (sgn && a[31]) ? -r : r;  // sign of the dividend
        return (sgn && (a[31] ^ b[31])) ? -q : q;
    endfunction

    function automatic logic [31:0] fwd_pick(input logic [4:0] addr, input logic [31:0] rf,
                                             input exe_pkg::fwd_t f1, f2);
        if (f2.valid && f2.we && f2.dest != 5'd0 && f2.dest == addr)
            return f2.data;
        if (f1.valid && f1.we && f1.dest != 5'd0 && f1.dest == addr)
            return f1.data;
        return rf;
    endfunction

    // plain add of rj and rkd with no forward hits on r1 and r2
    function automatic exe_pkg::issue_t base_instr(input logic [31:0] a, b);
        exe_pkg::issue_t ins;
        ins            = '0;
        ins.alu_op.add = 1'b1;
        ins.gr_we      = 1'b1;
        ins.dest       = 5'(rand_bits(5)) | 5'd1;
        ins.rf_raddr1  = 5'd1;
        ins.rf_raddr2  = 5'd2;
        ins.rj_value   = a;
        ins.rkd_value  = b;
        ins.pc         = rand_bits(30) << 2;
        return ins;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    task automatic present(input exe_pkg::issue_t ins);
        in_bus   = ins;
        in_valid = 1'b1;
    endtask

    // holds the instruction until accepted, then waits for the record
    task automatic finish_issue(output exe_pkg::wb_t got, output logic stalled);
        logic accepted;
        accepted = 1'b0;
        stalled  = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = stall_n && ws_ready;
            stalled  = stalled || !stall_n;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        while (!out_valid)
        begin
            @(posedge clk);
            #1;
        end
        got = out_bus;
    endtask

    task automatic check_reset_state();
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("br_bus.flush", 32'(br_bus.flush), 32'd0);
        check_value("bpu_upd.valid", 32'(bpu_upd.valid), 32'd0);
        check_value("stall_n", 32'(stall_n), 32'd1);
        end_test("reset");
    endtask

    task automatic sweep_alu_ops();
        exe_pkg::issue_t ins;
        exe_pkg::wb_t    got;
        logic            stalled;
        logic [31:0]     a;
        logic [31:0]     b;
        for (int op = 0; op < 12; op++)
        begin
            for (int n = 0; n < 20; n++)
            begin
                a          = rand_bits(32);
                b          = rand_bits(32);
                ins        = base_instr(a, b);
                ins.alu_op = exe_pkg::alu_op_t'(12'b1 << op);
                if (op == 11)
                begin
                    ins.branch_ctl.src2_is_imm = 1'b1;  // lui reads the immediate
                    ins.imm                    = b;
                    ins.rkd_value              = ~b;
                end
                present(ins);
                finish_issue(got, stalled);
                check_value("out_bus.result", got.result, alu_model(op, a, b));
                check_value("out_bus.dest", 32'(got.dest), 32'(ins.dest));
                check_value("out_bus.gr_we", 32'(got.gr_we), 32'd1);
                @(posedge clk);  // idle cycle so out_valid must drop
                #1;
                check_value("out_valid", 32'(out_valid), 32'd0);
            end
        end
        end_test("alu");
    endtask

    task automatic forward_operands();
        exe_pkg::issue_t ins;
        exe_pkg::wb_t    got;
        logic            stalled;
        logic [4:0]      regs [4];
        logic [31:0]     rj;
        logic [31:0]     rkd;
        regs = '{5'd0, 5'd3, 5'd4, 5'd3};  // r0 plus two live sources
        for (int n = 0; n < 40; n++)
        begin
            ins           = base_instr(rand_bits(32), rand_bits(32));
            ins.rf_raddr1 = regs[rand_bits(2)];
            ins.rf_raddr2 = regs[rand_bits(2)];
            fwd_1.valid   = rand_bits(2) != 0;
            fwd_1.we      = rand_bits(2) != 0;
            fwd_1.dest    = regs[rand_bits(2)];
            fwd_1.data    = rand_bits(32);
            fwd_2.valid   = rand_bits(2) != 0;
            fwd_2.we      = rand_bits(2) != 0;
            fwd_2.dest    = regs[rand_bits(2)];
            fwd_2.data    = rand_bits(32);
            rj  = fwd_pick(ins.rf_raddr1, ins.rj_value, fwd_1, fwd_2);
            rkd = fwd_pick(ins.rf_raddr2, ins.rkd_value, fwd_1, fwd_2);
            present(ins);
            finish_issue(got, stalled);
            check_value("out_bus.result", got.result, rj + rkd);
        end
        fwd_1 = '0;
        fwd_2 = '0;
        end_test("forward");
    endtask

    task automatic exercise_divider();
        exe_pkg::issue_t ins;
        exe_pkg::wb_t    got;
        logic            stalled;
        logic [31:0]     a;
        logic [31:0]     b;
        for (int n = 0; n < 16; n++)
        begin
            a = rand_bits(32);
            b = rand_bits(32) >> rand_bits(5);  // spread of divisor sizes
            if (b == 32'd0)
                b = 32'd1;
            ins            = base_instr(a, b);
            ins.use_div    = 1'b1;
            ins.div_signed = n[0];
            ins.use_mod    = n[1];
            present(ins);
            finish_issue(got, stalled);
            check_count++;
            if (!stalled)
            begin
                error_count++;
                $display("error at %0t: stall_n never went low during a divide", $time);
            end
            check_value("out_bus.result", got.result, div_model(a, b, n[0], n[1]));
            check_value("out_bus.dest", 32'(got.dest), 32'(ins.dest));
            ins = base_instr(a, b);
            present(ins);
            finish_issue(got, stalled);
            check_value("out_bus.result", got.result, a + b);
        end
        end_test("div");
    endtask

    task automatic resolve_branches();
        exe_pkg::issue_t ins;
        exe_pkg::wb_t    got;
        logic            stalled;
        logic [31:0]     a;
        logic [31:0]     b;
        logic            zero;
        logic            less;
        logic            taken;
        logic [31:0]     target;
        int              kind;
        for (int n = 0; n < 36; n++)
        begin
            kind = n % 6;
            a    = rand_bits(32);
            b    = lfsr_bit() ? a : rand_bits(32);  // equal operands about half the time
            ins  = base_instr(a, b);
            ins.gr_we                 = 1'b0;
            ins.imm                   = rand_bits(32);
            ins.branch_ctl.may_jump   = 1'b1;
            ins.branch_ctl.pred_taken = lfsr_bit();
            case (kind)
                0:
                begin
                    ins.branch_ctl.use_zero  = 1'b1;  // beq
                    ins.branch_ctl.need_zero = 1'b1;
                end
                1:
                begin
                    ins.branch_ctl.use_zero  = 1'b1;  // bne
                end
                2:
                begin
                    ins.alu_op               = '0;
                    ins.alu_op.slt           = 1'b1;
                    ins.branch_ctl.use_less  = 1'b1;
                    ins.branch_ctl.need_less = 1'b1;
                end
                3:
                begin
                    ins.alu_op               = '0;
                    ins.alu_op.sltu          = 1'b1;
                    ins.branch_ctl.use_less  = 1'b1;  // bgeu
                end
                4:
                begin
                    ins.branch_ctl.use_rj_value = 1'b1;  // jirl links pc + 4
                    ins.branch_ctl.src1_is_pc   = 1'b1;
                    ins.src2_is_4               = 1'b1;
                    ins.gr_we                   = 1'b1;
                end
                default:
                begin
                end
            endcase
            zero   = (a == b);
            less   = (kind == 2) ? ($signed(a) < $signed(b)) : (a < b);
            taken  = (!ins.branch_ctl.use_less && !ins.branch_ctl.use_zero)
                   || (ins.branch_ctl.use_less && less == ins.branch_ctl.need_less)
                   || (ins.branch_ctl.use_zero && zero == ins.branch_ctl.need_zero);
            target = (ins.branch_ctl.use_rj_value ? a : ins.pc) + ins.imm;
            present(ins);
            #2;
            check_value("br_bus.flush", 32'(br_bus.flush),
                        32'(taken != ins.branch_ctl.pred_taken));
            check_value("br_bus.target", br_bus.target, taken ? target : ins.pc + 32'd4);
            check_value("bpu_upd.valid", 32'(bpu_upd.valid), 32'd1);
            check_value("bpu_upd.pc", bpu_upd.pc, ins.pc);
            check_value("bpu_upd.taken", 32'(bpu_upd.taken), 32'(taken));
            check_value("bpu_upd.mispredict", 32'(bpu_upd.mispredict),
                        32'(taken != ins.branch_ctl.pred_taken));
            check_value("bpu_upd.target", bpu_upd.target, target);
            finish_issue(got, stalled);
            if (kind == 4)
                check_value("out_bus.result", got.result, ins.pc + 32'd4);
            check_value("out_bus.gr_we", 32'(got.gr_we), 32'(ins.gr_we));
            @(negedge clk);  // branch still on the bus with in_valid low
            check_value("br_bus.flush", 32'(br_bus.flush), 32'd0);
            check_value("bpu_upd.valid", 32'(bpu_upd.valid), 32'd0);
            @(posedge clk);
            #1;
        end
        end_test("branch");
    endtask

    task automatic hold_writeback();
        exe_pkg::issue_t first;
        exe_pkg::issue_t second;
        exe_pkg::wb_t    held;
        exe_pkg::wb_t    got;
        logic            stalled;
        first  = base_instr(rand_bits(32), rand_bits(32));
        second = base_instr(rand_bits(32), rand_bits(32));
        second.alu_op        = '0;
        second.alu_op.op_xor = 1'b1;
        present(first);
        finish_issue(held, stalled);
        check_value("out_bus.result", held.result, first.rj_value + first.rkd_value);
        ws_ready = 1'b0;
        present(second);
        repeat (6)
        begin
            @(posedge clk);
            #1;
            check_value("ready", 32'(ready), 32'd0);
            check_value("out_valid", 32'(out_valid), 32'd1);
            check_value("out_bus.result", out_bus.result, held.result);
            check_value("out_bus.pc", out_bus.pc, held.pc);
        end
        ws_ready = 1'b1;
        #1;
        check_value("ready", 32'(ready), 32'd1);
        finish_issue(got, stalled);
        check_value("out_bus.result", got.result, second.rj_value ^ second.rkd_value);
        check_value("out_bus.pc", got.pc, second.pc);
        end_test("backpressure");
    endtask

    initial
    begin
        lfsr_state  = 16'd19270;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_bus      = '0;
        fwd_1       = '0;
        fwd_2       = '0;
        ws_ready    = 1'b1;
        check_count = 0;
        error_count = 0;
        test_errors = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        sweep_alu_ops();
        forward_operands();
        exercise_divider();
        resolve_branches();
        hold_writeback();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
